//--- peSnn.f
src/nocPkg.sv
src/pePkg.sv
src/depacketizer.sv
src/spikeConv.sv
src/packetizer.sv
src/peTop.sv
tb/peTop_properties.sv
tb/peTopTb.sv

//--- run.sh
#!/bin/sh
# compile the processing element with its testbench and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert \
    --top-module peTopTb \
    -Mdir obj_dir \
    -f peSnn.f

# exit status carries the verdict
./obj_dir/VpeTopTb

//--- src/depacketizer.sv
// decode stage
// checks the destination, splits the packet into fields, drops bad packets
module depacketizer import nocPkg::*, pePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  packetT  inPacket,
    input  logic    inValid,
    output logic    inReady,
    output decodedT dec,
    output logic    decValid,
    input  logic    decReady
);

    logic    inFire;    // packet taken this cycle
    logic    goodPkt;   // addressed here with a legal row
    logic    addrHit;
    logic    rowOk;
    decodedT fields;

    // one entry, ready when empty or when the entry leaves now
    assign inReady = !decValid || decReady;
    assign inFire  = inValid && inReady;

    assign addrHit = (inPacket.dest == PE_ADDR);
    assign rowOk   = (int'(inPacket.filterRow) < NUM_ROWS);  // row 3 names nothing
    assign goodPkt = addrHit && rowOk;

    // address fields stripped here
    always_comb begin
        fields.isFilter = inPacket.isFilter;
        fields.timestep = inPacket.timestep;
        fields.row      = inPacket.filterRow;
        fields.data     = inPacket.data;
    end

    // valid follows the accepted packet
    // foreign or bad packets are swallowed
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (inReady) begin
            decValid <= inFire && goodPkt;  // empties when nothing good arrives
        end
    end

    // payload, only loaded by a good packet
    always_ff @(posedge clk) begin
        if (inFire && goodPkt) begin
            dec <= fields;
        end
    end

endmodule

//--- src/nocPkg.sv
// network-on-chip packet layout
// field widths, node addresses and the packet struct
package nocPkg;

    localparam int FILTER_WIDTH = 8;                 // bits per weight
    localparam int DATA_WIDTH   = 3 * FILTER_WIDTH;  // one filter row or one spike row
    localparam int ADDR_WIDTH   = 3;
    localparam int ROW_WIDTH    = 2;
    localparam int PACKET_WIDTH = 34;

    typedef logic [ADDR_WIDTH-1:0] nodeAddrT;
    typedef logic [DATA_WIDTH-1:0] dataT;
    typedef logic [ROW_WIDTH-1:0]  rowFieldT;

    localparam nodeAddrT PE_ADDR  = 3'd2;  // this element
    localparam nodeAddrT OUT_DEST = 3'd7;  // output collector

    // high bits first
    // dest sits in bits 2:0, src in 5:3
    // timestep bit 6, type bit 7, row 9:8, data from bit 10 up
    typedef struct packed {
        dataT     data;       // three weights or three spike bits
        rowFieldT filterRow;  // row 3 is not a legal row
        logic     isFilter;   // 0 ifmap, 1 filter
        logic     timestep;
        nodeAddrT src;
        nodeAddrT dest;
    } packetT;

endpackage

//--- src/packetizer.sv
// result stage
// captures the result, builds the output packet and holds it
// until the network takes it
module packetizer import nocPkg::*, pePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  resultT res,
    input  logic   resValid,
    output logic   resReady,
    output packetT outPacket,
    output logic   outValid,
    input  logic   outReady
);

    resultT heldRes;     // captured result
    logic   heldValid;
    logic   moveOut;     // captured result goes to the output register
    logic   resFire;
    packetT built;

    assign moveOut  = heldValid && (!outValid || outReady);
    assign resReady = !heldValid || moveOut;
    assign resFire  = resValid && resReady;

    // output packet from the captured result
    always_comb begin
        built           = packetT'({PACKET_WIDTH{1'b0}});  // row, type, data high bits zero
        built.dest      = OUT_DEST;
        built.src       = PE_ADDR;
        built.timestep  = heldRes.timestep;
        built.isFilter  = 1'b0;
        built.filterRow = '0;
        built.data      = dataT'(heldRes.spike);            // spike in bit 0
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            heldValid <= 1'b0;
            outValid  <= 1'b0;
        end else begin
            if (resFire) begin
                heldValid <= 1'b1;
            end else if (moveOut) begin
                heldValid <= 1'b0;
            end
            if (moveOut) begin
                outValid <= 1'b1;
            end else if (outReady) begin
                outValid <= 1'b0;   // sent, nothing behind it
            end
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (resFire) begin
            heldRes <= res;
        end
        if (moveOut) begin
            outPacket <= built;     // steady while outReady is low
        end
    end

endmodule

//--- src/pePkg.sv
// neuron side types of the processing element
// weight, potential and threshold, decoded fields, result, FSM states
package pePkg;
    import nocPkg::*;

    localparam int NUM_ROWS     = 3;   // 3x3 filter, rows and columns alike
    localparam int OUTPUT_WIDTH = 12;
    localparam int ACC_WIDTH    = OUTPUT_WIDTH + 2;  // room for potential plus a full window
    localparam int THRESHOLD    = 16;
    localparam int POT_MAX      = 2 ** (OUTPUT_WIDTH - 1) - 1;
    localparam int POT_MIN      = -(2 ** (OUTPUT_WIDTH - 1));

    typedef logic signed [FILTER_WIDTH-1:0] weightT;
    typedef logic signed [OUTPUT_WIDTH-1:0] potentialT;
    typedef logic signed [ACC_WIDTH-1:0]    accT;
    typedef logic [1:0]                     rowSelT;
    typedef logic [NUM_ROWS-1:0]            spikesT;  // one bit per column

    // packet with the address fields stripped
    typedef struct packed {
        logic   isFilter;
        logic   timestep;
        rowSelT row;
        dataT   data;   // spikes live in data[2:0] for ifmap
    } decodedT;

    typedef struct packed {
        logic timestep;
        logic spike;
    } resultT;

    typedef enum logic {
        COLLECT,  // waiting for the rows of a timestep
        FIRE      // result waiting for the packetizer
    } convStateT;

endpackage

//--- src/peTop.sv
// processing element top level
// decode, execute and result stages chained by valid/ready links
module peTop import nocPkg::*, pePkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  packetT inPacket,
    input  logic   inValid,
    output logic   inReady,
    output packetT outPacket,
    output logic   outValid,
    input  logic   outReady
);

    decodedT dec;        // decode to execute
    logic    decValid;
    logic    decReady;
    resultT  res;        // execute to result
    logic    resValid;
    logic    resReady;

    depacketizer depacketizer_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inPacket (inPacket),
        .inValid  (inValid),
        .inReady  (inReady),
        .dec      (dec),
        .decValid (decValid),
        .decReady (decReady)
    );

    spikeConv spikeConv_inst (
        .clk      (clk),
        .rstN     (rstN),
        .dec      (dec),
        .decValid (decValid),
        .decReady (decReady),
        .res      (res),
        .resValid (resValid),
        .resReady (resReady)
    );

    packetizer packetizer_inst (
        .clk       (clk),
        .rstN      (rstN),
        .res       (res),
        .resValid  (resValid),
        .resReady  (resReady),
        .outPacket (outPacket),
        .outValid  (outValid),
        .outReady  (outReady)
    );

endmodule

//--- src/spikeConv.sv
// execute stage
// filter store, spike row collection, weighted sum into the membrane
// potential, threshold firing
module spikeConv import nocPkg::*, pePkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  decodedT dec,
    input  logic    decValid,
    output logic    decReady,
    output resultT  res,
    output logic    resValid,
    input  logic    resReady
);

    convStateT state;
    weightT    filter [NUM_ROWS][NUM_ROWS];   // [row][column]
    spikesT    spikeRows [NUM_ROWS];          // spikes of the current timestep
    spikesT    curSpikes [NUM_ROWS];          // same, with the arriving row merged in
    spikesT    rowMask;                       // rows seen this timestep
    spikesT    nextMask;
    potentialT potential;
    potentialT nextPotSat;

    logic decFire;
    logic ifmapIn;
    logic rowDone;      // this packet completes the window
    logic willFire;
    logic resLeave;
    accT  weightSum;
    accT  rawPot;
    accT  afterFire;

    // one result held, ready once it is gone or going
    assign resValid = (state == FIRE);
    assign resLeave = resValid && resReady;
    assign decReady = (state == COLLECT) || resReady;
    assign decFire  = decValid && decReady;
    assign ifmapIn  = decFire && !dec.isFilter;

    assign nextMask = rowMask | spikesT'(1 << dec.row);
    assign rowDone  = ifmapIn && (nextMask == '1);

    // window sum with the incoming row already in place
    always_comb begin
        curSpikes = spikeRows;
        curSpikes[dec.row] = dec.data[NUM_ROWS-1:0];
        weightSum = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < NUM_ROWS; c++) begin
                if (curSpikes[r][c]) begin
                    weightSum = weightSum + accT'(filter[r][c]);  // sign extended
                end
            end
        end
    end

    // add, fire, subtract, then clamp to the potential range
    always_comb begin
        rawPot    = accT'(potential) + weightSum;
        willFire  = (rawPot >= accT'(THRESHOLD));
        afterFire = willFire ? rawPot - accT'(THRESHOLD) : rawPot;
        if (afterFire > accT'(POT_MAX)) begin
            nextPotSat = potentialT'(POT_MAX);
        end else if (afterFire < accT'(POT_MIN)) begin
            nextPotSat = potentialT'(POT_MIN);
        end else begin
            nextPotSat = potentialT'(afterFire);
        end
    end

    // control state and weights
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= COLLECT;
            rowMask   <= '0;
            potential <= '0;
            for (int r = 0; r < NUM_ROWS; r++) begin
                for (int c = 0; c < NUM_ROWS; c++) begin
                    filter[r][c] <= '0;
                end
            end
        end else begin
            if (resLeave) begin
                state <= COLLECT;
            end
            if (decFire && dec.isFilter) begin
                for (int c = 0; c < NUM_ROWS; c++) begin
                    filter[dec.row][c] <= weightT'(dec.data[c*FILTER_WIDTH +: FILTER_WIDTH]);
                end
            end
            if (rowDone) begin
                potential <= nextPotSat;    // carries over to the next timestep
                rowMask   <= '0;
                state     <= FIRE;          // wins over the leave above
            end else if (ifmapIn) begin
                rowMask <= nextMask;
            end
        end
    end

    // spike rows and result payload
    always_ff @(posedge clk) begin
        if (ifmapIn) begin
            spikeRows[dec.row] <= dec.data[NUM_ROWS-1:0];  // repeat overwrites
        end
        if (rowDone) begin
            res.timestep <= dec.timestep;
            res.spike    <= willFire;
        end
    end

endmodule

//--- tb/peTopTb.sv
// testbench for the processing element
// xorshift stimulus, transaction level reference model, output scoreboard,
// watchdog and latency check
module peTopTb import nocPkg::*, pePkg::*; ();

    localparam int          CLK_PERIOD   = 4;
    localparam int          RESET_CYCLES = 16;
    localparam logic [31:0] SEED         = 32'heaf5_e4cc;
    localparam int          STEPS        = 30;   // timesteps per random test
    localparam int          BAD_STEPS    = 6;    // timesteps mixed with bad packets
    localparam int          SAT_STEPS    = 8;
    localparam int          DRAIN_CYCLES = 50;
    localparam int          TOTAL_PKTS   = (STEPS * 3 + (STEPS / 10) * 3)  // firing
                                         + STEPS * 5                       // shuffled rows
                                         + BAD_STEPS * 6                   // filtering
                                         + 3 + STEPS * 3                   // back-pressure
                                         + 2 * (3 + SAT_STEPS * 3)         // saturation
                                         + 3;                              // latency
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * TOTAL_PKTS + DRAIN_CYCLES + 200;

    logic   clk;
    logic   rstN;
    packetT inPacket;
    logic   inValid;
    logic   inReady;
    packetT outPacket;
    logic   outValid;
    logic   outReady;

    logic [31:0] rngState;     // stimulus stream
    logic [31:0] readyState;   // separate stream for outReady
    logic        randReady;    // outReady toggles when set
    logic        gapsOn;       // idle cycles between input packets
    logic        tsBit;

    // reference model
    weightT     mFilter [NUM_ROWS][NUM_ROWS];
    logic [2:0] mSpikes [NUM_ROWS];
    logic [2:0] mMask;
    int         mPot;
    packetT     expQ [$];      // expected output packets in order

    peTop peTop_inst (
        .clk       (clk),
        .rstN      (rstN),
        .inPacket  (inPacket),
        .inValid   (inValid),
        .inReady   (inReady),
        .outPacket (outPacket),
        .outValid  (outValid),
        .outReady  (outReady)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    function automatic packetT makePacket(input nodeAddrT dest, input nodeAddrT src,
                                          input logic isFilter, input rowFieldT row,
                                          input logic ts, input dataT data);
        packetT p;
        p.data      = data;
        p.filterRow = row;
        p.isFilter  = isFilter;
        p.timestep  = ts;
        p.src       = src;
        p.dest      = dest;
        return p;
    endfunction

    task checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %s got 0x%0h, expected 0x%0h", name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // model one accepted input packet
    task modelPacket(input packetT p);
        int     sum;
        int     raw;
        logic   fire;
        packetT e;
        if (p.dest == PE_ADDR && p.filterRow != 2'd3) begin
            if (p.isFilter) begin
                for (int c = 0; c < NUM_ROWS; c++) begin
                    mFilter[p.filterRow][c] = weightT'(p.data[c*FILTER_WIDTH +: FILTER_WIDTH]);
                end
            end else begin
                mSpikes[p.filterRow] = p.data[2:0];   // repeat overwrites
                mMask[p.filterRow]   = 1'b1;
                if (mMask == 3'b111) begin
                    sum = 0;
                    for (int r = 0; r < NUM_ROWS; r++) begin
                        for (int c = 0; c < NUM_ROWS; c++) begin
                            if (mSpikes[r][c]) sum += int'(mFilter[r][c]);
                        end
                    end
                    raw  = mPot + sum;
                    fire = (raw >= THRESHOLD);
                    if (fire) raw = raw - THRESHOLD;
                    if (raw > POT_MAX) raw = POT_MAX;       // clamp after the subtract
                    else if (raw < POT_MIN) raw = POT_MIN;
                    mPot  = raw;
                    mMask = '0;
                    e = makePacket(OUT_DEST, PE_ADDR, 1'b0, 2'd0, p.timestep, dataT'(fire));
                    expQ.push_back(e);
                end
            end
        end
    endtask

    task idleCycles(input int n);
        inValid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // entered and left 1 unit after a rising edge
    task sendPacket(input packetT p);
        logic        taken;
        logic [31:0] r;
        inPacket = p;
        inValid  = 1'b1;
        taken    = 1'b0;
        while (!taken) begin
            #2;                 // inReady settled by mid cycle
            taken = inReady;
            @(posedge clk);
            #1;
        end
        inValid = 1'b0;
        modelPacket(p);
        if (gapsOn) begin
            r = nextRand();
            if (r[1:0] == 2'b00) idleCycles(int'(r[3:2]) + 1);
        end
    endtask

    task loadFilterRow(input int row, input dataT weights);
        sendPacket(makePacket(PE_ADDR, 3'd1, 1'b1, rowFieldT'(row), tsBit, weights));
    endtask

    task loadRandomFilter();
        logic [31:0] r;
        for (int row = 0; row < NUM_ROWS; row++) begin
            r = nextRand();
            loadFilterRow(row, r[23:0]);
        end
    endtask

    task sendSpikeRow(input int row, input logic [2:0] spikes);
        sendPacket(makePacket(PE_ADDR, 3'd1, 1'b0, rowFieldT'(row), tsBit, dataT'(spikes)));
    endtask

    // rows 0 to 2 in order with random or dense spikes
    task runTimestep(input logic dense);
        logic [31:0] r;
        tsBit = ~tsBit;
        for (int row = 0; row < NUM_ROWS; row++) begin
            r = nextRand();
            sendSpikeRow(row, dense ? 3'b111 : r[2:0]);
        end
    endtask

    // shuffled rows with repeats of early rows before the last one
    task runShuffledTimestep();
        int          order [NUM_ROWS];
        int          j;
        int          tmp;
        int          extra;
        logic [31:0] r;
        order = '{0, 1, 2};
        for (int i = NUM_ROWS - 1; i > 0; i--) begin
            r = nextRand();
            j = int'(r[7:0]) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        tsBit = ~tsBit;
        r = nextRand();
        sendSpikeRow(order[0], r[2:0]);
        sendSpikeRow(order[1], r[5:3]);
        extra = int'(r[9:8]) % 3;
        repeat (extra) begin
            r = nextRand();
            sendSpikeRow(order[int'(r[4])], r[2:0]);
        end
        r = nextRand();
        sendSpikeRow(order[2], r[2:0]);
    endtask

    // foreign dest or row 3 on a filter or ifmap packet
    task sendBadPacket();
        logic [31:0] r;
        nodeAddrT    dest;
        r    = nextRand();
        dest = r[4:2];
        if (dest == PE_ADDR) dest = 3'd5;
        if (r[0]) sendPacket(makePacket(PE_ADDR, 3'd1, r[1], 2'd3, tsBit, r[31:8]));
        else sendPacket(makePacket(dest, 3'd1, r[1], r[6:5], tsBit, r[31:8]));
    endtask

    task measureLatency();
        int          n;
        logic [31:0] r;
        tsBit = ~tsBit;
        r = nextRand();
        for (int row = 0; row < NUM_ROWS; row++) begin
            sendSpikeRow(row, r[row*3 +: 3]);
        end
        n = 0;                  // third row taken on the last edge
        while (!outValid) begin
            @(posedge clk);
            #1;
            n++;
        end
        checkValue("outValid latency", 64'(n), 64'd3);
    endtask

    // outReady driver
    initial begin
        outReady   = 1'b0;
        readyState = ~SEED;
        forever begin
            @(posedge clk);
            #1;
            if (randReady) begin
                readyState = xorshift(readyState);
                outReady   = readyState[0];
            end else begin
                outReady = 1'b1;
            end
        end
    end

    // scoreboard sampling mid cycle where outputs are stable
    initial begin
        packetT e;
        forever begin
            @(posedge clk);
            #3;
            if (rstN && outValid && outReady) begin
                if (expQ.size() == 0) begin
                    $display("output packet arrived when none was expected");
                    $display("RESULT: FAIL");
                    $fatal(1, "unexpected output");
                end
                e = expQ.pop_front();
                checkValue("outPacket", 64'(outPacket), 64'(e));
            end
        end
    end

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout: the run hung and never reached the end of the tests");
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rngState  = SEED;
        randReady = 1'b0;
        gapsOn    = 1'b0;
        tsBit     = 1'b0;
        inPacket  = '0;
        inValid   = 1'b0;
        rstN      = 1'b0;
        mPot      = 0;
        mMask     = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            mSpikes[r] = '0;
            for (int c = 0; c < NUM_ROWS; c++) mFilter[r][c] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rstN = 1'b1;
        idleCycles(2);

        // random filters reloaded every ten steps
        for (int s = 0; s < STEPS; s++) begin
            if (s % 10 == 0) loadRandomFilter();
            runTimestep(1'b0);
        end
        for (int s = 0; s < STEPS; s++) runShuffledTimestep();

        // bad packets between good rows
        for (int s = 0; s < BAD_STEPS; s++) begin
            tsBit = ~tsBit;
            for (int row = 0; row < NUM_ROWS; row++) begin
                sendBadPacket();
                sendSpikeRow(row, 3'(nextRand()));
            end
        end

        // random outReady and input gaps
        loadRandomFilter();
        randReady = 1'b1;
        gapsOn    = 1'b1;
        for (int s = 0; s < STEPS; s++) runTimestep(1'b0);
        randReady = 1'b0;
        gapsOn    = 1'b0;

        // pin high and then pin low
        for (int row = 0; row < NUM_ROWS; row++) loadFilterRow(row, {3{8'h7f}});
        repeat (SAT_STEPS) runTimestep(1'b1);
        for (int row = 0; row < NUM_ROWS; row++) loadFilterRow(row, {3{8'h80}});
        repeat (SAT_STEPS) runTimestep(1'b1);

        idleCycles(20);         // pipeline empty before timing
        measureLatency();

        idleCycles(DRAIN_CYCLES);
        if (expQ.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("%0d expected output packets never arrived", expQ.size());
            $display("RESULT: FAIL");
            $fatal(1, "missing output packets");
        end
    end

endmodule

//--- tb/peTop_properties.sv
// handshake and reset assertions for the processing element
// bound into peTop, watches the outer links and inner valids
module peTopProperties import nocPkg::*; (
    input logic   clk,
    input logic   rstN,
    input packetT inPacket,
    input logic   inValid,
    input logic   inReady,
    input packetT outPacket,
    input logic   outValid,
    input logic   outReady,
    input logic   decValid,   // depacketizer to spikeConv
    input logic   resValid    // spikeConv to packetizer
);

    // nothing valid while reset is held
    resetQuiet: assert property (@(posedge clk)
        !rstN |-> !inValid && !decValid && !resValid && !outValid)
        else $error("valid signal high during reset");

    // stalled output keeps its packet
    outHold: assert property (@(posedge clk) disable iff (!rstN)
        outValid && !outReady |=> outValid && $stable(outPacket))
        else $error("output packet changed while stalled");

    // stalled input keeps its packet
    inHold: assert property (@(posedge clk) disable iff (!rstN)
        inValid && !inReady |=> inValid && $stable(inPacket))
        else $error("input packet changed while stalled");

endmodule

bind peTop peTopProperties peTopProperties_inst (
    .clk       (clk),
    .rstN      (rstN),
    .inPacket  (inPacket),
    .inValid   (inValid),
    .inReady   (inReady),
    .outPacket (outPacket),
    .outValid  (outValid),
    .outReady  (outReady),
    .decValid  (decValid),
    .resValid  (resValid)
);
